/* sources.f */
+incdir+source
source/loongarch_isa_pkg.sv
source/branch_types_pkg.sv
source/branch_decoder.sv
source/branch_alu.sv
source/branch_predictor.sv
source/branch_unit.sv
test/branch_unit_chk.sv
test/branch_unit_tb.sv

/* Bender.yml */
package:
  name: branch_unit

sources:
  - include_dirs:
      - source
    files:
      - source/loongarch_isa_pkg.sv
      - source/branch_types_pkg.sv
      - source/branch_decoder.sv
      - source/branch_alu.sv
      - source/branch_predictor.sv
      - source/branch_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/branch_unit_chk.sv
      - test/branch_unit_tb.sv

/* test/branch_unit_tb.sv */
`default_nettype none

module branch_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 20;

    logic                     clk;
    logic                     reset;
    branch_types_pkg::bus32_t fetch_pc;
    logic                     pred_taken;
    branch_types_pkg::bus32_t pred_target;
    logic                     ex_valid;
    branch_types_pkg::bus32_t ex_pc;
    branch_types_pkg::bus32_t ex_inst;
    branch_types_pkg::bus32_t ex_reg1;
    branch_types_pkg::bus32_t ex_reg2;
    logic                     ex_pred_taken;
    branch_types_pkg::bus32_t ex_pred_target;
    logic                     res_flush;
    branch_types_pkg::bus32_t res_redirect_pc;
    logic                     res_link_valid;
    branch_types_pkg::bus32_t res_link_value;

    int seed = 62177;
    int link_errors = 0;
    int timeouts = 0;
    int total_errors;

    branch_unit u_dut (
        .clk             (clk),
        .reset           (reset),
        .fetch_pc        (fetch_pc),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .ex_valid        (ex_valid),
        .ex_pc           (ex_pc),
        .ex_inst         (ex_inst),
        .ex_reg1         (ex_reg1),
        .ex_reg2         (ex_reg2),
        .ex_pred_taken   (ex_pred_taken),
        .ex_pred_target  (ex_pred_target),
        .res_flush       (res_flush),
        .res_redirect_pc (res_redirect_pc),
        .res_link_valid  (res_link_valid),
        .res_link_value  (res_link_value)
    );

    always #2 clk = ~clk;

    function automatic branch_types_pkg::bus32_t encode_offs16(
        input loongarch_isa_pkg::opcode_t op,
        input logic [15:0]                offs
    );
        return {op, offs, 5'd4, 5'd5};
    endfunction

    function automatic branch_types_pkg::bus32_t encode_offs26(
        input loongarch_isa_pkg::opcode_t op,
        input logic [25:0]                offs
    );
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic present_slot(input logic valid, input branch_types_pkg::bus32_t pc,
                                input branch_types_pkg::bus32_t inst,
                                input branch_types_pkg::bus32_t r1,
                                input branch_types_pkg::bus32_t r2,
                                input logic ptaken, input branch_types_pkg::bus32_t ptarget);
        @(posedge clk);
        #0.5;
        ex_valid       = valid;
        ex_pc          = pc;
        ex_inst        = inst;
        ex_reg1        = r1;
        ex_reg2        = r2;
        ex_pred_taken  = ptaken;
        ex_pred_target = ptarget;
    endtask

    task automatic idle_slot();
        present_slot(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic check_link(input branch_types_pkg::bus32_t pc,
                              input branch_types_pkg::bus32_t inst,
                              input branch_types_pkg::bus32_t r1);
        int n;
        n = 0;
        present_slot(1'b1, pc, inst, r1, 32'h0, 1'b0, 32'h0);
        idle_slot();
        while (!res_link_valid && n < WAIT_LIMIT) begin
            @(posedge clk);
            #0.5;
            n++;
        end
        if (!res_link_valid) begin
            $display("Timed out waiting for the link result of pc %h", pc);
            timeouts++;
        end else if (res_link_value != pc + 32'd4) begin
            $display("FAIL at %0t: link value %h for pc %h, expected %h",
                     $time, res_link_value, pc, pc + 32'd4);
            link_errors++;
        end
    endtask

    // Random branches over a small PC window, so entries get trained and aliased.
    task automatic random_slots(input int count);
        loongarch_isa_pkg::opcode_t op;
        branch_types_pkg::bus32_t   pc;
        branch_types_pkg::bus32_t   inst;
        branch_types_pkg::bus32_t   r1;
        branch_types_pkg::bus32_t   r2;
        branch_types_pkg::bus32_t   off16;
        branch_types_pkg::bus32_t   off26;
        branch_types_pkg::bus32_t   target;
        int                         pick;
        for (int i = 0; i < count; i++) begin
            pick = $random(seed);
            op   = loongarch_isa_pkg::OP_JIRL + 6'($unsigned(pick) % 9);
            op   = (pick[7:5] == 3'd0) ? 6'h00 : op;
            inst = $random(seed);
            inst[31:26] = op;
            pc   = 32'h1c00_0000 | ($random(seed) & 32'h0000_0ffc);
            r1   = $random(seed);
            r2   = (pick[12:11] == 2'd0) ? r1 :
                   ((pick[12:11] == 2'd1) ? r1 ^ 32'h8000_0000 : $random(seed));
            off16  = {{14{inst[25]}}, inst[25:10], 2'b00};
            off26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            target = (op == loongarch_isa_pkg::OP_JIRL) ? r1 + off16 :
                     ((op == loongarch_isa_pkg::OP_B || op == loongarch_isa_pkg::OP_BL) ?
                      pc + off26 : pc + off16);
            present_slot(pick[10:8] != 3'd0, pc, inst, r1, r2, pick[13],
                         pick[14] ? target : $random(seed));
            fetch_pc = pick[15] ? pc : pc ^ 32'h0000_0100;
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        fetch_pc       = 32'h1c00_0000;
        ex_valid       = 1'b0;
        ex_pc          = 32'h0;
        ex_inst        = 32'h0;
        ex_reg1        = 32'h0;
        ex_reg2        = 32'h0;
        ex_pred_taken  = 1'b0;
        ex_pred_target = 32'h0;
        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;
        idle_slot();

        // Operands that differ only in the sign bit split signed from unsigned.
        present_slot(1'b1, 32'h1c00_0010, encode_offs16(loongarch_isa_pkg::OP_BLT, 16'h0008),
                     32'h8000_0001, 32'h0000_0001, 1'b0, 32'h0);
        present_slot(1'b1, 32'h1c00_0014, encode_offs16(loongarch_isa_pkg::OP_BLTU, 16'h0008),
                     32'h8000_0001, 32'h0000_0001, 1'b1, 32'h1c00_0034);
        present_slot(1'b1, 32'h1c00_0018, encode_offs16(loongarch_isa_pkg::OP_BGE, 16'hfff0),
                     32'h0000_0001, 32'h8000_0001, 1'b1, 32'h1c00_0000);
        present_slot(1'b1, 32'h1c00_001c, encode_offs16(loongarch_isa_pkg::OP_BGEU, 16'hfff0),
                     32'h0000_0001, 32'h8000_0001, 1'b0, 32'h0);
        present_slot(1'b1, 32'h1c00_0020, encode_offs16(loongarch_isa_pkg::OP_BNE, 16'hffe0),
                     32'h1234_5678, 32'h1234_5679, 1'b0, 32'h0);
        present_slot(1'b1, 32'h1c00_0024, encode_offs16(loongarch_isa_pkg::OP_BEQ, 16'h0004),
                     32'h5, 32'h6, 1'b1, 32'h1c00_0034);
        present_slot(1'b1, 32'h1c00_2000, encode_offs26(loongarch_isa_pkg::OP_B, 26'h3ff_fc00),
                     32'h0, 32'h0, 1'b0, 32'h0);
        present_slot(1'b1, 32'h1c00_0028, 32'h0010_0000, 32'h0, 32'h0, 1'b1, 32'h0);
        present_slot(1'b0, 32'h1c00_002c, encode_offs26(loongarch_isa_pkg::OP_BL, 26'h10),
                     32'h0, 32'h0, 1'b0, 32'h0);
        idle_slot();

        check_link(32'h1c00_0100, encode_offs26(loongarch_isa_pkg::OP_BL, 26'h000_0040), 32'h0);
        check_link(32'h1c00_0200, encode_offs26(loongarch_isa_pkg::OP_BL, 26'h3ff_ff00), 32'h0);
        check_link(32'h1c00_0300, encode_offs16(loongarch_isa_pkg::OP_JIRL, 16'hfffc),
                   32'h1c00_8000);

        // Train one PC taken twice, probe an alias, then train it back down.
        fetch_pc = 32'h1c00_0240;
        repeat (2) begin
            present_slot(1'b1, 32'h1c00_0240, encode_offs16(loongarch_isa_pkg::OP_BEQ, 16'h0010),
                         32'h7, 32'h7, 1'b0, 32'h0);
        end
        repeat (3) idle_slot();
        fetch_pc = 32'h1c00_0340;
        repeat (2) idle_slot();
        fetch_pc = 32'h1c00_0240;
        repeat (2) begin
            present_slot(1'b1, 32'h1c00_0240, encode_offs16(loongarch_isa_pkg::OP_BEQ, 16'h0010),
                         32'h7, 32'h8, 1'b1, 32'h1c00_0280);
        end
        repeat (3) idle_slot();

        random_slots(400);
        repeat (3) idle_slot();

        total_errors = link_errors + timeouts + u_dut.u_chk.assert_errors;
        $display("Summary: %0d link errors, %0d timeouts, %0d assertion failures",
                 link_errors, timeouts, u_dut.u_chk.assert_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #50us;
        $display("Simulation did not finish within its time limit");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/branch_unit_chk.sv */
`default_nettype none

`include "branch_params.svh"

module branch_unit_chk (
    input logic                      clk,
    input logic                      reset,
    input branch_types_pkg::bus32_t  fetch_pc,
    input logic                      pred_taken,
    input branch_types_pkg::bus32_t  pred_target,
    input logic                      ex_valid,
    input branch_types_pkg::bus32_t  ex_pc,
    input branch_types_pkg::bus32_t  ex_inst,
    input branch_types_pkg::bus32_t  ex_reg1,
    input branch_types_pkg::bus32_t  ex_reg2,
    input logic                      ex_pred_taken,
    input branch_types_pkg::bus32_t  ex_pred_target,
    input logic                      res_flush,
    input branch_types_pkg::bus32_t  res_redirect_pc,
    input logic                      res_link_valid,
    input branch_types_pkg::bus32_t  res_link_value,
    input logic                      train_en,
    input logic                      train_taken,
    input branch_types_pkg::bus32_t  train_pc,
    input branch_types_pkg::bus32_t  train_target
);

    timeunit 1ns;
    timeprecision 100ps;

    loongarch_isa_pkg::opcode_t   op;
    logic                         is_cond;
    logic                         is_jump;
    logic                         is_link;
    logic                         slot;
    logic                         cond_taken;
    logic                         act_taken;
    logic                         exp_flush;
    branch_types_pkg::bus32_t     imm16;
    branch_types_pkg::bus32_t     imm26;
    branch_types_pkg::bus32_t     act_target;
    branch_types_pkg::bus32_t     act_next;

    branch_types_pkg::bht_count_t sh_count [`BHT_ENTRIES];
    logic                         sh_valid [`BHT_ENTRIES];
    branch_types_pkg::btb_tag_t   sh_tag [`BHT_ENTRIES];
    branch_types_pkg::bus32_t     sh_target [`BHT_ENTRIES];
    branch_types_pkg::bht_index_t tr_idx;
    branch_types_pkg::bht_index_t fe_idx;
    logic                         sh_pred;

    int assert_errors = 0;

    assign op    = ex_inst[31:26];
    assign imm16 = {{14{ex_inst[25]}}, ex_inst[25:10], 2'b00};
    assign imm26 = {{4{ex_inst[9]}}, ex_inst[9:0], ex_inst[25:10], 2'b00};

    always_comb begin
        cond_taken = 1'b0;
        is_cond    = 1'b1;
        case (op)
            loongarch_isa_pkg::OP_BEQ:  cond_taken = (ex_reg1 == ex_reg2);
            loongarch_isa_pkg::OP_BNE:  cond_taken = (ex_reg1 != ex_reg2);
            loongarch_isa_pkg::OP_BLT:  cond_taken = ($signed(ex_reg1) < $signed(ex_reg2));
            loongarch_isa_pkg::OP_BGE:  cond_taken = ($signed(ex_reg1) >= $signed(ex_reg2));
            loongarch_isa_pkg::OP_BLTU: cond_taken = (ex_reg1 < ex_reg2);
            loongarch_isa_pkg::OP_BGEU: cond_taken = (ex_reg1 >= ex_reg2);
            default:                    is_cond = 1'b0;
        endcase
    end

    assign is_link = (op == loongarch_isa_pkg::OP_BL) || (op == loongarch_isa_pkg::OP_JIRL);
    assign is_jump = is_link || (op == loongarch_isa_pkg::OP_B);
    assign slot    = ex_valid && (is_cond || is_jump);

    assign act_taken  = is_jump || cond_taken;
    assign act_target = (op == loongarch_isa_pkg::OP_JIRL) ? ex_reg1 + imm16 :
                        (is_jump ? ex_pc + imm26 : ex_pc + imm16);
    assign act_next   = act_taken ? act_target : ex_pc + 32'd4;
    assign exp_flush  = (act_taken != ex_pred_taken) ||
                        (act_taken && (ex_pred_target != act_target));

    // Shadow of the predictor, trained only from the registered resolve outputs.
    assign tr_idx  = train_pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS];
    assign fe_idx  = fetch_pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS];
    assign sh_pred = sh_valid[fe_idx] && (sh_count[fe_idx] >= 2'd2) &&
                     (sh_tag[fe_idx] == fetch_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS]);

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                sh_count[i] <= 2'd1;
                sh_valid[i] <= 1'b0;
            end
        end else if (train_en && train_taken) begin
            sh_count[tr_idx]  <= (sh_count[tr_idx] == 2'd3) ? 2'd3 : sh_count[tr_idx] + 2'd1;
            sh_valid[tr_idx]  <= 1'b1;
            sh_tag[tr_idx]    <= train_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
            sh_target[tr_idx] <= train_target;
        end else if (train_en) begin
            sh_count[tr_idx]  <= (sh_count[tr_idx] == 2'd0) ? 2'd0 : sh_count[tr_idx] - 2'd1;
        end
    end

    a_reset_clear: assert property (@(posedge clk)
        reset |=> (!res_flush && !res_link_valid && !train_en))
        else begin
            assert_errors++;
            $error("resolve outputs not cleared after reset");
        end

    a_flush: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (res_flush == $past(slot && exp_flush)))
        else begin
            assert_errors++;
            $error("res_flush does not follow the flush rule");
        end

    a_redirect: assert property (@(posedge clk) disable iff (reset)
        slot |=> (res_redirect_pc == $past(act_next)))
        else begin
            assert_errors++;
            $error("res_redirect_pc differs from the actual next PC");
        end

    a_link: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (res_link_valid == $past(slot && is_link)))
        else begin
            assert_errors++;
            $error("res_link_valid raised for the wrong slot");
        end

    a_link_value: assert property (@(posedge clk) disable iff (reset)
        (slot && is_link) |=> (res_link_value == $past(ex_pc + 32'd4)))
        else begin
            assert_errors++;
            $error("res_link_value is not pc+4");
        end

    a_train: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (train_en == $past(slot)))
        else begin
            assert_errors++;
            $error("train_en does not match the resolved slot");
        end

    // The shadow learns from these, so they are held to the resolve rules here.
    a_train_data: assert property (@(posedge clk) disable iff (reset)
        slot |=> ((train_pc == $past(ex_pc)) && (train_taken == $past(act_taken)) &&
                  (train_target == $past(act_next))))
        else begin
            assert_errors++;
            $error("training data differs from the resolved branch");
        end

    a_predict: assert property (@(posedge clk) disable iff (reset)
        (pred_taken == sh_pred) && (!sh_pred || (pred_target == sh_target[fe_idx])))
        else begin
            assert_errors++;
            $error("fetch lookup disagrees with the shadow predictor");
        end

endmodule

bind branch_unit branch_unit_chk u_chk (.*);

`default_nettype wire

/* source/branch_unit.sv */
`default_nettype none

`include "branch_params.svh"

module branch_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  branch_types_pkg::bus32_t  fetch_pc,
    output logic                      pred_taken,
    output branch_types_pkg::bus32_t  pred_target,
    input  logic                      ex_valid,
    input  branch_types_pkg::bus32_t  ex_pc,
    input  branch_types_pkg::bus32_t  ex_inst,
    input  branch_types_pkg::bus32_t  ex_reg1,
    input  branch_types_pkg::bus32_t  ex_reg2,
    input  logic                      ex_pred_taken,
    input  branch_types_pkg::bus32_t  ex_pred_target,
    output logic                      res_flush,
    output branch_types_pkg::bus32_t  res_redirect_pc,
    output logic                      res_link_valid,
    output branch_types_pkg::bus32_t  res_link_value
);

    loongarch_isa_pkg::branch_op_t branch_op;

    logic                     is_branch;
    logic                     flush;
    logic                     upd_taken;
    branch_types_pkg::bus32_t upd_target;
    branch_types_pkg::bus32_t link_value;

    logic                     slot_branch;
    logic                     slot_link;

    logic                     train_en;
    logic                     train_taken;
    branch_types_pkg::bus32_t train_pc;
    branch_types_pkg::bus32_t train_target;

    branch_decoder u_decoder (
        .inst      (ex_inst),
        .branch_op (branch_op)
    );

    branch_alu u_alu (
        .pc          (ex_pc),
        .inst        (ex_inst),
        .reg1        (ex_reg1),
        .reg2        (ex_reg2),
        .branch_op   (branch_op),
        .pred_taken  (ex_pred_taken),
        .pred_target (ex_pred_target),
        .is_branch   (is_branch),
        .flush       (flush),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .link_value  (link_value)
    );

    // Every resolved branch trains the predictor, B and BL included.
    assign slot_branch = ex_valid && is_branch;
    assign slot_link   = slot_branch && ((branch_op == loongarch_isa_pkg::BR_BL) ||
                                         (branch_op == loongarch_isa_pkg::BR_JIRL));

    always_ff @(posedge clk) begin
        if (reset) begin
            res_flush       <= 1'b0;
            res_link_valid  <= 1'b0;
            train_en        <= 1'b0;
            res_redirect_pc <= `BRANCH_RESET_PC;
        end else begin
            res_flush       <= slot_branch && flush;
            res_link_valid  <= slot_link;
            train_en        <= slot_branch;
            res_redirect_pc <= upd_target;
        end
    end

    always_ff @(posedge clk) begin
        res_link_value <= link_value;
        train_pc       <= ex_pc;
        train_taken    <= upd_taken;
        train_target   <= upd_target;
    end

    branch_predictor u_predictor (
        .clk          (clk),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .train_en     (train_en),
        .train_taken  (train_taken),
        .train_pc     (train_pc),
        .train_target (train_target)
    );

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
`default_nettype none

`include "branch_params.svh"

module branch_predictor (
    input  logic                      clk,
    input  logic                      reset,
    input  branch_types_pkg::bus32_t  fetch_pc,
    output logic                      pred_taken,
    output branch_types_pkg::bus32_t  pred_target,
    input  logic                      train_en,
    input  logic                      train_taken,
    input  branch_types_pkg::bus32_t  train_pc,
    input  branch_types_pkg::bus32_t  train_target
);

    branch_types_pkg::bht_count_t bht [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0]      btb_valid;
    branch_types_pkg::btb_tag_t   btb_tag [`BHT_ENTRIES];
    branch_types_pkg::bus32_t     btb_target [`BHT_ENTRIES];

    branch_types_pkg::bht_index_t fetch_idx;
    branch_types_pkg::btb_tag_t   fetch_tag;
    branch_types_pkg::bht_index_t train_idx;
    branch_types_pkg::btb_tag_t   train_tag;

    logic fetch_hit;

    assign fetch_idx = fetch_pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS];
    assign fetch_tag = fetch_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
    assign train_idx = train_pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS];
    assign train_tag = train_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];

    // Lookup is combinational so fetch gets its answer in the same cycle.
    assign fetch_hit   = btb_valid[fetch_idx] && (btb_tag[fetch_idx] == fetch_tag);
    assign pred_taken  = fetch_hit && bht[fetch_idx][1];
    assign pred_target = pred_taken ? btb_target[fetch_idx] : fetch_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                bht[i] <= `BHT_INIT_COUNT;
            end
            btb_valid <= '0;
        end else if (train_en) begin
            if (train_taken) begin
                if (bht[train_idx] != branch_types_pkg::CNT_MAX) begin
                    bht[train_idx] <= bht[train_idx] + 2'd1;
                end
                btb_valid[train_idx] <= 1'b1;
            end else begin
                if (bht[train_idx] != branch_types_pkg::CNT_MIN) begin
                    bht[train_idx] <= bht[train_idx] - 2'd1;
                end
            end
        end
    end

    // Tag and target are only meaningful behind a valid bit.
    always_ff @(posedge clk) begin
        if (train_en && train_taken) begin
            btb_tag[train_idx]    <= train_tag;
            btb_target[train_idx] <= train_target;
        end
    end

endmodule

`default_nettype wire

/* source/branch_alu.sv */
`default_nettype none

module branch_alu (
    input  branch_types_pkg::bus32_t       pc,
    input  branch_types_pkg::bus32_t       inst,
    input  branch_types_pkg::bus32_t       reg1,
    input  branch_types_pkg::bus32_t       reg2,
    input  loongarch_isa_pkg::branch_op_t  branch_op,
    input  logic                           pred_taken,
    input  branch_types_pkg::bus32_t       pred_target,
    output logic                           is_branch,
    output logic                           flush,
    output logic                           upd_taken,
    output branch_types_pkg::bus32_t       upd_target,
    output branch_types_pkg::bus32_t       link_value
);

    loongarch_isa_pkg::offs16_t offs16;
    loongarch_isa_pkg::offs26_t offs26;

    branch_types_pkg::bus32_t off16_ext;
    branch_types_pkg::bus32_t off26_ext;
    branch_types_pkg::bus32_t pc_plus4;
    branch_types_pkg::bus32_t target;

    logic eq;
    logic lt_signed;
    logic lt_unsigned;
    logic taken;

    // The 26-bit offset keeps its high part in bits 9 to 0.
    assign offs16 = inst[25:10];
    assign offs26 = {inst[9:0], inst[25:10]};

    assign off16_ext = {{14{offs16[15]}}, offs16, 2'b00};
    assign off26_ext = {{4{offs26[25]}}, offs26, 2'b00};

    assign pc_plus4   = pc + 32'd4;
    assign link_value = pc_plus4;

    assign eq          = (reg1 == reg2);
    assign lt_signed   = ($signed(reg1) < $signed(reg2));
    assign lt_unsigned = (reg1 < reg2);

    assign is_branch = (branch_op != loongarch_isa_pkg::BR_NONE);

    always_comb begin
        taken  = 1'b0;
        target = pc + off16_ext;
        case (branch_op)
            loongarch_isa_pkg::BR_BEQ: begin
                taken = eq;
            end
            loongarch_isa_pkg::BR_BNE: begin
                taken = !eq;
            end
            loongarch_isa_pkg::BR_BLT: begin
                taken = lt_signed;
            end
            loongarch_isa_pkg::BR_BGE: begin
                taken = !lt_signed;
            end
            loongarch_isa_pkg::BR_BLTU: begin
                taken = lt_unsigned;
            end
            loongarch_isa_pkg::BR_BGEU: begin
                taken = !lt_unsigned;
            end
            loongarch_isa_pkg::BR_B, loongarch_isa_pkg::BR_BL: begin
                taken  = 1'b1;
                target = pc + off26_ext;
            end
            loongarch_isa_pkg::BR_JIRL: begin
                taken  = 1'b1;
                target = reg1 + off16_ext;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // Compare the outcome against what fetch guessed.
    always_comb begin
        case ({is_branch, taken, pred_taken})
            3'b111: begin
                flush = (pred_target != target);
            end
            3'b110, 3'b101: begin
                flush = 1'b1;
            end
            default: begin
                flush = 1'b0;
            end
        endcase
    end

    // Actual next PC; a not-taken branch falls through.
    assign upd_taken  = is_branch && taken;
    assign upd_target = upd_taken ? target : pc_plus4;

endmodule

`default_nettype wire

/* source/branch_decoder.sv */
`default_nettype none

module branch_decoder (
    input  branch_types_pkg::bus32_t       inst,
    output loongarch_isa_pkg::branch_op_t  branch_op
);

    loongarch_isa_pkg::opcode_t opcode;

    assign opcode = inst[31:26];

    // Only the major opcode matters for the branch formats.
    always_comb begin
        case (opcode)
            loongarch_isa_pkg::OP_JIRL: begin
                branch_op = loongarch_isa_pkg::BR_JIRL;
            end
            loongarch_isa_pkg::OP_B: begin
                branch_op = loongarch_isa_pkg::BR_B;
            end
            loongarch_isa_pkg::OP_BL: begin
                branch_op = loongarch_isa_pkg::BR_BL;
            end
            loongarch_isa_pkg::OP_BEQ: begin
                branch_op = loongarch_isa_pkg::BR_BEQ;
            end
            loongarch_isa_pkg::OP_BNE: begin
                branch_op = loongarch_isa_pkg::BR_BNE;
            end
            loongarch_isa_pkg::OP_BLT: begin
                branch_op = loongarch_isa_pkg::BR_BLT;
            end
            loongarch_isa_pkg::OP_BGE: begin
                branch_op = loongarch_isa_pkg::BR_BGE;
            end
            loongarch_isa_pkg::OP_BLTU: begin
                branch_op = loongarch_isa_pkg::BR_BLTU;
            end
            loongarch_isa_pkg::OP_BGEU: begin
                branch_op = loongarch_isa_pkg::BR_BGEU;
            end
            default: begin
                branch_op = loongarch_isa_pkg::BR_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/branch_types_pkg.sv */
`default_nettype none

`include "branch_params.svh"

package branch_types_pkg;

    // PC, instruction or operand word.
    typedef logic [31:0] bus32_t;

    // Two-bit saturating counter; 2 and 3 mean taken.
    typedef logic [1:0] bht_count_t;

    localparam bht_count_t CNT_MIN = 2'd0;
    localparam bht_count_t CNT_MAX = 2'd3;

    typedef logic [`BHT_INDEX_BITS-1:0] bht_index_t;
    typedef logic [`BTB_TAG_BITS-1:0] btb_tag_t;

endpackage

`default_nettype wire

/* source/loongarch_isa_pkg.sv */
`default_nettype none

package loongarch_isa_pkg;

    // Major opcode in instruction bits 31 to 26.
    typedef logic [5:0] opcode_t;

    // Immediate fields of the branch formats.
    typedef logic [15:0] offs16_t;
    typedef logic [25:0] offs26_t;

    localparam opcode_t OP_JIRL = 6'h13;
    localparam opcode_t OP_B    = 6'h14;
    localparam opcode_t OP_BL   = 6'h15;
    localparam opcode_t OP_BEQ  = 6'h16;
    localparam opcode_t OP_BNE  = 6'h17;
    localparam opcode_t OP_BLT  = 6'h18;
    localparam opcode_t OP_BGE  = 6'h19;
    localparam opcode_t OP_BLTU = 6'h1a;
    localparam opcode_t OP_BGEU = 6'h1b;

    // Branch operation handed from the decoder to the branch ALU.
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } branch_op_t;

endpackage

`default_nettype wire

/* source/branch_params.svh */
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Predictor history table and target buffer share one index.
`define BHT_INDEX_BITS 6
`define BHT_ENTRIES (1 << `BHT_INDEX_BITS)

// Instructions are word aligned, so the index starts above bit 1.
`define BHT_INDEX_LSB 2

// Tag bits sit directly above the index bits.
`define BTB_TAG_BITS 8
`define BTB_TAG_LSB (`BHT_INDEX_LSB + `BHT_INDEX_BITS)

// Counters come out of reset weakly not taken.
`define BHT_INIT_COUNT 2'd1

// Boot vector of the core.
`define BRANCH_RESET_PC 32'h1c00_0000

`endif
